// File: cache_pkg.sv
package cache_pkg;

    localparam int unsigned ADDR_W = 16;
    localparam int unsigned TAG_W  = 5;
    localparam int unsigned IDX_W  = 8;
    localparam int unsigned OFF_W  = 3;

    localparam int unsigned MEM_LAT = 2; // main memory read latency, cycles

    typedef logic [15:0] word_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] index;
        logic [OFF_W-1:0] offset;
    } addr_fields_t;

    // same address word, raw toward memory, split toward the ways
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        addr_fields_t      f;
    } cache_addr_t;

    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        COMP   = 4'd1,
        WB_0   = 4'd2,
        WB_1   = 4'd3,
        WB_2   = 4'd4,
        WB_3   = 4'd5,
        FILL_0 = 4'd6,
        FILL_1 = 4'd7,
        FILL_2 = 4'd8,
        FILL_3 = 4'd9,
        FILL_4 = 4'd10,
        FILL_5 = 4'd11
    } ctrl_state_t;

endpackage

// File: req_intake.sv
`timescale 1ns/10ps

module req_intake import cache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        req_wr,
    input  cache_addr_t req_addr,
    input  word_t       req_wdata,
    input  logic        take,
    output logic        buf_valid,
    output logic        buf_wr,
    output cache_addr_t buf_addr,
    output word_t       buf_wdata
);

    assign req_ready = ~buf_valid; // ready only when empty

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid <= 1'b0;
        end else if (take) begin
            buf_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            buf_valid <= 1'b1;
        end
    end

    // held stable for the whole miss sequence
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            buf_wr    <= req_wr;
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
        end
    end

    a_take_full: assert property (
        @(posedge clk) disable iff (!arst_n) take |-> buf_valid
    );

endmodule

// File: cache_way_array.sv
`timescale 1ns/10ps

module cache_way_array import cache_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             en,
    input  logic [IDX_W-1:0] index,
    input  logic [OFF_W-1:0] offset,
    input  logic [TAG_W-1:0] tag,
    input  word_t            wdata,
    input  logic             write,
    input  logic             comp,
    input  logic             valid_in,
    output logic             hit,
    output logic             valid,
    output logic             dirty,
    output logic [TAG_W-1:0] tag_out,
    output word_t            rdata
);

    localparam int unsigned NSETS  = 1 << IDX_W;
    localparam int unsigned NWORDS = NSETS * 4;

    logic [TAG_W-1:0] tag_mem  [NSETS];
    word_t            data_mem [NWORDS];
    logic [NSETS-1:0] valid_mem;
    logic [NSETS-1:0] dirty_mem;

    logic [IDX_W+1:0] word_idx;
    logic             wr_cmp;
    logic             wr_fill;

    assign word_idx = {index, offset[2:1]}; // offset bit 0 ignored

    assign valid   = valid_mem[index];
    assign dirty   = dirty_mem[index];
    assign tag_out = tag_mem[index];
    assign rdata   = data_mem[word_idx];
    assign hit     = valid && (tag_out == tag);

    assign wr_cmp  = en && write && comp && hit; // write hit
    assign wr_fill = en && write && !comp;       // line fill

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_mem <= '0;
            dirty_mem <= '0;
        end else if (wr_cmp) begin
            dirty_mem[index] <= 1'b1;
        end else if (wr_fill) begin
            valid_mem[index] <= valid_in;
            dirty_mem[index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_cmp || wr_fill) begin
            data_mem[word_idx] <= wdata;
        end
        if (wr_fill) begin
            tag_mem[index] <= tag;
        end
    end

endmodule

// File: cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             buf_valid,
    input  logic             buf_wr,
    input  cache_addr_t      buf_addr,
    input  word_t            buf_wdata,
    output logic             take,
    output logic             en0,
    output logic             en1,
    output logic [IDX_W-1:0] index,
    output logic [OFF_W-1:0] offset,
    output logic [TAG_W-1:0] tag,
    output word_t            wdata,
    output logic             write,
    output logic             comp,
    output logic             valid_in,
    input  logic             hit0,
    input  logic             hit1,
    input  logic             valid0,
    input  logic             valid1,
    input  logic             dirty0,
    input  logic             dirty1,
    input  logic [TAG_W-1:0] tag_out0,
    input  logic [TAG_W-1:0] tag_out1,
    input  word_t            rdata0,
    input  word_t            rdata1,
    output logic [15:0]      mem_addr,
    output word_t            mem_wdata,
    output logic             mem_write,
    output logic             mem_read,
    input  word_t            mem_rdata,
    output logic             res_valid,
    output word_t            res_data,
    output logic             res_hit,
    input  logic             res_ready
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic             victim_q;  // round robin bit, flips per fill
    logic             way_q;     // way chosen for this miss
    word_t            rd_q;      // requested word caught during fill
    logic             way_sel;
    logic             victim_dirty;
    logic [TAG_W-1:0] tag_sel;
    word_t            rdata_sel;
    logic [1:0]       wb_step;
    logic [2:0]       fill_step;
    logic [1:0]       fill_word;
    logic             word_match;

    // invalid way first (way 0 preferred), else the victim bit
    assign way_sel      = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : victim_q);
    assign victim_dirty = way_sel ? (valid1 && dirty1) : (valid0 && dirty0);

    assign tag_sel   = way_q ? tag_out1 : tag_out0;
    assign rdata_sel = way_q ? rdata1 : rdata0;

    assign wb_step    = 2'(state_q - WB_0);
    assign fill_step  = 3'(state_q - FILL_0);
    assign fill_word  = 2'(fill_step - MEM_LAT); // data lags the read by MEM_LAT
    assign word_match = (buf_addr.f.offset[2:1] == fill_word);

    always_comb begin
        state_d   = state_q;
        take      = 1'b0;
        en0       = 1'b0;
        en1       = 1'b0;
        index     = buf_addr.f.index;
        offset    = buf_addr.f.offset;
        tag       = buf_addr.f.tag;
        wdata     = buf_wdata;
        write     = 1'b0;
        comp      = 1'b0;
        valid_in  = 1'b0;
        mem_addr  = buf_addr.flat;
        mem_wdata = rdata_sel;
        mem_write = 1'b0;
        mem_read  = 1'b0;
        res_valid = 1'b0;
        res_data  = '0;
        res_hit   = 1'b0;

        case (state_q)
            IDLE: begin
                if (buf_valid && res_ready) begin
                    state_d = COMP;
                end
            end
            COMP: begin
                en0   = 1'b1; // only a hitting way takes the write
                en1   = 1'b1;
                comp  = 1'b1;
                write = buf_wr;
                if (hit0 || hit1) begin
                    res_valid = 1'b1;
                    res_hit   = 1'b1;
                    res_data  = buf_wr ? '0 : (hit0 ? rdata0 : rdata1);
                    take      = 1'b1;
                    state_d   = IDLE;
                end else if (victim_dirty) begin
                    state_d = WB_0;
                end else begin
                    state_d = FILL_0;
                end
            end
            WB_0, WB_1, WB_2, WB_3: begin
                en0       = ~way_q;
                en1       = way_q;
                offset    = {wb_step, 1'b0};
                mem_addr  = {tag_sel, buf_addr.f.index, wb_step, 1'b0};
                mem_write = 1'b1;
                state_d   = (state_q == WB_3) ? FILL_0 : ctrl_state_t'(state_q + 1);
            end
            default: begin // FILL_0 to FILL_5
                en0 = ~way_q;
                en1 = way_q;
                if (fill_step < 3'd4) begin
                    mem_read = 1'b1;
                    mem_addr = {buf_addr.flat[15:3], fill_step[1:0], 1'b0};
                end
                if (fill_step >= MEM_LAT) begin
                    write    = 1'b1;
                    valid_in = 1'b1;
                    offset   = {fill_word, 1'b0};
                    wdata    = (buf_wr && word_match) ? buf_wdata : mem_rdata;
                end
                if (state_q == FILL_5) begin
                    comp      = buf_wr; // marks the line dirty on a write miss
                    res_valid = 1'b1;
                    res_data  = buf_wr ? '0 : (word_match ? mem_rdata : rd_q);
                    take      = 1'b1;
                    state_d   = IDLE;
                end else begin
                    state_d = ctrl_state_t'(state_q + 1);
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= IDLE;
            victim_q <= 1'b0;
            way_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == COMP && !(hit0 || hit1)) begin
                way_q <= way_sel;
            end
            if (state_q == FILL_5) begin
                victim_q <= ~victim_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write && !comp && !buf_wr && word_match) begin
            rd_q <= mem_rdata;
        end
    end

    // writeback only ever drains a dirty victim line
    a_wb_dirty: assert property (
        @(posedge clk) disable iff (!arst_n) mem_write |-> (way_q ? dirty1 : dirty0)
    );

    // a line is never resident in both ways
    a_one_hit: assert property (
        @(posedge clk) disable iff (!arst_n) !(hit0 && hit1)
    );

    a_res_room: assert property (
        @(posedge clk) disable iff (!arst_n) res_valid |-> res_ready
    );

endmodule

// File: main_mem.sv
`timescale 1ns/10ps

module main_mem import cache_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [ADDR_W-1:0] mem_addr,
    input  word_t             mem_wdata,
    input  logic              mem_write,
    input  logic              mem_read,
    output word_t             mem_rdata
);

    localparam int unsigned NWORDS = 1 << (ADDR_W - 1);

    word_t              mem [NWORDS];
    word_t              rd_pipe [MEM_LAT];
    logic [MEM_LAT-1:0] rd_vld;

    // every word starts as its own byte address inverted
    initial begin
        for (int i = 0; i < NWORDS; i++) begin
            mem[i] = ~word_t'(i << 1);
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[mem_addr[ADDR_W-1:1]] <= mem_wdata;
        end
        rd_pipe[0] <= mem[mem_addr[ADDR_W-1:1]];
        for (int s = 1; s < MEM_LAT; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld <= '0;
        end else begin
            rd_vld <= {rd_vld[MEM_LAT-2:0], mem_read};
        end
    end

    assign mem_rdata = rd_vld[MEM_LAT-1] ? rd_pipe[MEM_LAT-1] : '0;

    a_no_rw: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_read && mem_write)
    );

endmodule

// File: resp_out.sv
`timescale 1ns/10ps

module resp_out import cache_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  res_valid,
    input  word_t res_data,
    input  logic  res_hit,
    output logic  res_ready,
    output logic  resp_valid,
    input  logic  resp_ready,
    output word_t resp_rdata,
    output logic  resp_hit
);

    assign res_ready = ~resp_valid || resp_ready; // empty or draining

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else if (res_valid && res_ready) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            resp_rdata <= res_data;
            resp_hit   <= res_hit;
        end
    end

    a_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_rdata) && $stable(resp_hit))
    );

endmodule

// File: cache_top.sv
`timescale 1ns/10ps

module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        req_wr,
    input  cache_addr_t req_addr,
    input  word_t       req_wdata,
    output logic        resp_valid,
    input  logic        resp_ready,
    output word_t       resp_rdata,
    output logic        resp_hit
);

    logic             buf_valid, buf_wr, take;
    cache_addr_t      buf_addr;
    word_t            buf_wdata;

    logic             en0, en1, write, comp, valid_in;
    logic [IDX_W-1:0] index;
    logic [OFF_W-1:0] offset;
    logic [TAG_W-1:0] tag, tag_out0, tag_out1;
    word_t            wdata, rdata0, rdata1;
    logic             hit0, hit1, valid0, valid1, dirty0, dirty1;

    logic [ADDR_W-1:0] mem_addr;
    word_t             mem_wdata, mem_rdata;
    logic              mem_write, mem_read;

    logic  res_valid, res_hit, res_ready;
    word_t res_data;

    req_intake u_intake (
        .clk, .arst_n, .req_valid, .req_ready, .req_wr, .req_addr, .req_wdata,
        .take, .buf_valid, .buf_wr, .buf_addr, .buf_wdata
    );

    cache_ctrl u_ctrl (
        .clk, .arst_n, .buf_valid, .buf_wr, .buf_addr, .buf_wdata, .take,
        .en0, .en1, .index, .offset, .tag, .wdata, .write, .comp, .valid_in,
        .hit0, .hit1, .valid0, .valid1, .dirty0, .dirty1,
        .tag_out0, .tag_out1, .rdata0, .rdata1,
        .mem_addr, .mem_wdata, .mem_write, .mem_read, .mem_rdata,
        .res_valid, .res_data, .res_hit, .res_ready
    );

    cache_way_array way0 (
        .clk, .arst_n, .en(en0), .index, .offset, .tag, .wdata, .write, .comp,
        .valid_in, .hit(hit0), .valid(valid0), .dirty(dirty0), .tag_out(tag_out0),
        .rdata(rdata0)
    );

    cache_way_array way1 (
        .clk, .arst_n, .en(en1), .index, .offset, .tag, .wdata, .write, .comp,
        .valid_in, .hit(hit1), .valid(valid1), .dirty(dirty1), .tag_out(tag_out1),
        .rdata(rdata1)
    );

    main_mem u_mem (
        .clk, .arst_n, .mem_addr, .mem_wdata, .mem_write, .mem_read, .mem_rdata
    );

    resp_out u_resp (
        .clk, .arst_n, .res_valid, .res_data, .res_hit, .res_ready,
        .resp_valid, .resp_ready, .resp_rdata, .resp_hit
    );

endmodule

// File: tb_cache.sv
`timescale 1ns/10ps

module tb_cache;

    localparam int MAX_CASES    = 64;
    localparam int FIELDS       = 6;  // op, addr, wdata, exp rdata, exp hit, name
    localparam int CLK_HALF     = 5;
    localparam int RESET_CYCLES = 10;
    localparam int TAIL_CYCLES  = 20;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    logic        req_ready;
    logic        req_wr;
    logic [15:0] req_addr;
    logic [15:0] req_wdata;
    logic        resp_valid;
    logic        resp_ready;
    logic [15:0] resp_rdata;
    logic        resp_hit;

    logic [15:0] case_mem [MAX_CASES*FIELDS];
    int          num_cases;
    int          num_resp;
    int          errors;
    bit          loaded;
    bit          running;
    int          pending [$]; // case numbers waiting for a response

    cache_top uut (
        .clk, .arst_n, .req_valid, .req_ready, .req_wr, .req_addr, .req_wdata,
        .resp_valid, .resp_ready, .resp_rdata, .resp_hit
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic string case_name(input logic [15:0] idx);
        case (idx)
            16'd0:   return "cold_miss";
            16'd1:   return "line_hit";
            16'd2:   return "write_hit";
            16'd3:   return "read_back";
            16'd4:   return "write_miss";
            16'd5:   return "line_neighbour";
            16'd6:   return "second_tag";
            16'd7:   return "both_resident";
            16'd8:   return "dirty_evict";
            16'd9:   return "survivor_hit";
            16'd10:  return "evicted_reread";
            16'd11:  return "refill";
            16'd12:  return "back_to_back";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_response(input int k);
        logic [15:0] exp_data;
        logic        exp_hit;
        string       name;
        exp_data = case_mem[k*FIELDS+3];
        exp_hit  = case_mem[k*FIELDS+4][0];
        name     = case_name(case_mem[k*FIELDS+5]);
        if (resp_rdata !== exp_data) begin
            $display("FAIL %s (case %0d) rdata expected %h actual %h",
                     name, k, exp_data, resp_rdata);
            errors++;
        end
        if (resp_hit !== exp_hit) begin
            $display("FAIL %s (case %0d) hit expected %b actual %b",
                     name, k, exp_hit, resp_hit);
            errors++;
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req_wr     = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        resp_ready = 1'b0;
        errors     = 0;
        num_resp   = 0;
        num_cases  = 0;
        running    = 1'b0;
        loaded     = 1'b0;
        for (int i = 0; i < MAX_CASES*FIELDS; i++) begin
            case_mem[i] = 16'hffff; // op of ffff marks the end
        end
        $readmemh("cache_cases.txt", case_mem);
        while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != 16'hffff) begin
            num_cases++;
        end
        loaded = 1'b1;
        if (num_cases == 0) begin
            $display("the case file held no cases");
            errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        if (req_ready !== 1'b1) begin
            $display("FAIL reset_idle req_ready expected 1 actual %b", req_ready);
            errors++;
        end
        if (resp_valid !== 1'b0) begin
            $display("FAIL reset_idle resp_valid expected 0 actual %b", resp_valid);
            errors++;
        end
        running = 1'b1;

        for (int k = 0; k < num_cases; k++) begin
            req_valid <= 1'b1;
            req_wr    <= case_mem[k*FIELDS][0];
            req_addr  <= case_mem[k*FIELDS+1];
            req_wdata <= case_mem[k*FIELDS+2];
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk); // held until the buffer empties
            end
            pending.push_back(k);
        end
        req_valid <= 1'b0;
        while (num_resp < num_cases) begin
            @(posedge clk);
        end
        repeat (TAIL_CYCLES) @(posedge clk); // catches stray extra responses

        $display("%0d cases, %0d responses, %0d errors", num_cases, num_resp, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // random stall on the consumer side
    initial begin
        int unsigned seed_val;
        seed_val = 32'h27c0_b9d8;
        void'($urandom(seed_val));
        wait (running);
        forever begin
            @(posedge clk);
            resp_ready <= ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        if (resp_valid && resp_ready) begin
            if (pending.size() == 0) begin
                $display("a response arrived with no request outstanding");
                errors++;
            end else begin
                check_response(pending.pop_front());
            end
            num_resp++;
        end
    end

    initial begin
        wait (loaded);
        repeat (num_cases * 12 * 4 + RESET_CYCLES + TAIL_CYCLES + 50) @(posedge clk);
        $display("timeout, the cache stopped answering after %0d of %0d responses",
                 num_resp, num_cases);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: cache_cases.txt
// op addr wdata exp_rdata exp_hit name, all hex, op 0 read and 1 write
// name is an index into the testbench table of case names
// cold miss, then hits in the same line
0 0010 0000 ffef 0 0
0 0016 0000 ffe9 1 1
0 0012 0000 ffed 1 1
// write hit and read back
1 0014 a5a5 0000 1 2
0 0014 0000 a5a5 1 3
// write miss merges into the fetched line
1 0122 1234 0000 0 4
0 0122 0000 1234 1 3
0 0120 0000 fedf 1 5
0 0126 0000 fed9 1 5
// second tag on set 2 takes the empty way 1
0 0810 0000 f7ef 0 6
0 0014 0000 a5a5 1 7
0 0812 0000 f7ed 1 7
1 0816 5a5a 0000 1 2
// third tag, victim bit is 1 so dirty way 1 goes back to memory
0 1014 0000 efeb 0 8
0 0014 0000 a5a5 1 9
0 1010 0000 efef 1 1
// victim bit now 0, dirty way 0 evicted for the old tag 1 line
0 0816 0000 5a5a 0 a
0 0810 0000 f7ef 1 1
0 0014 0000 a5a5 0 b
0 1014 0000 efeb 0 b
// back to back traffic on other sets
0 7ff8 0000 8007 0 c
1 7ffa beef 0000 1 c
0 7ffa 0000 beef 1 c
0 7ffe 0000 8001 1 c
0 fffe 0000 0001 0 c
0 fff8 0000 0007 1 c
0 7ffa 0000 beef 1 c
1 0a0c 0f0f 0000 0 c
0 0a0a 0000 f5f5 1 c
0 0a0c 0000 0f0f 1 c

// File: filelist.f
cache_pkg.sv
req_intake.sv
cache_way_array.sv
cache_ctrl.sv
main_mem.sv
resp_out.sv
cache_top.sv
tb_cache.sv

// File: Bender.yml
package:
  name: two_way_cache

sources:
  - cache_pkg.sv
  - req_intake.sv
  - cache_way_array.sv
  - cache_ctrl.sv
  - main_mem.sv
  - resp_out.sv
  - cache_top.sv
  - target: simulation
    files:
      - tb_cache.sv
